// ==== all.f ====
source/core_pkg.sv
source/stage_pkg.sv
source/fetch.sv
source/decode.sv
source/execute.sv
source/mem.sv
source/core.sv
verification/core_checker.sv
verification/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# build the core testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_core -o Vtb_core -f all.f

./obj_dir/Vtb_core | tee sim.log

# the log decides the result
if grep -q "^TEST RESULT: PASS$" sim.log; then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed, see sim.log"
exit 1

// ==== source/core.sv ====
`timescale 1ns/1ps

module core import core_pkg::*, stage_pkg::*; #(
	parameter word_t P_RESET_PC = 32'h0000_0000
) (
	input  logic  i_clk,
	input  logic  i_rst_n,
	input  word_t i_instr,
	input  word_t i_read_data,
	output word_t o_instr_addr,
	output word_t o_data_addr,
	output word_t o_write_data,
	output logic  o_mem_write,
	output logic  o_mem_read
);

	if_id_t    if_id;
	id_ex_t    id_ex;
	ex_mem_t   ex_mem;
	mem_wb_t   mem_wb;
	logic      stall;
	logic      jump;
	word_t     jump_target;
	logic      branch;
	word_t     branch_target;
	reg_addr_t ex_dst;
	logic      ex_mem_read;

	fetch #(
		.P_RESET_PC(P_RESET_PC)
	) u_fetch (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_instr(i_instr),
		.i_stall(stall),
		.i_jump(jump),
		.i_jump_target(jump_target),
		.i_branch(branch),
		.i_branch_target(branch_target),
		.o_pc(o_instr_addr),
		.o_if_id(if_id)
	);

	// taken branch flushes decode as well as fetch
	decode u_decode (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_if_id(if_id),
		.i_flush(branch),
		.i_ex_dst(ex_dst),
		.i_ex_mem_read(ex_mem_read),
		.i_mem_wb(mem_wb),
		.o_id_ex(id_ex),
		.o_stall(stall),
		.o_jump(jump),
		.o_jump_target(jump_target)
	);

	execute u_execute (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_id_ex(id_ex),
		.i_ex_mem_fwd(ex_mem),
		.i_mem_wb(mem_wb),
		.o_ex_mem(ex_mem),
		.o_branch(branch),
		.o_branch_target(branch_target),
		.o_dst(ex_dst),
		.o_mem_read(ex_mem_read)
	);

	mem u_mem (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_ex_mem(ex_mem),
		.i_read_data(i_read_data),
		.o_mem_wb(mem_wb)
	);

	// data port straight from the execute/memory register
	assign o_data_addr  = ex_mem.result;
	assign o_write_data = ex_mem.store_data;
	assign o_mem_write  = ex_mem.valid && ex_mem.mem_write;
	assign o_mem_read   = ex_mem.valid && ex_mem.mem_read;

endmodule

// ==== source/core_pkg.sv ====
package core_pkg;

	// data and address word
	typedef logic [31:0] word_t;

	// register index, entry 0 reads as zero
	typedef logic [4:0] reg_addr_t;

	// primary opcode and special function field
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	localparam opcode_t OP_SPECIAL = 6'h00;
	localparam opcode_t OP_J       = 6'h02;
	localparam opcode_t OP_BEQ     = 6'h04;
	localparam opcode_t OP_ADDIU   = 6'h09;
	localparam opcode_t OP_LW      = 6'h23;
	localparam opcode_t OP_SW      = 6'h2b;

	// function codes under OP_SPECIAL
	localparam funct_t FN_ADDU = 6'h21;
	localparam funct_t FN_SUBU = 6'h23;
	localparam funct_t FN_AND  = 6'h24;
	localparam funct_t FN_OR   = 6'h25;
	localparam funct_t FN_SLT  = 6'h2a;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_e;

endpackage

// ==== source/decode.sv ====
`timescale 1ns/1ps

module decode import core_pkg::*, stage_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  if_id_t    i_if_id,
	input  logic      i_flush,
	input  reg_addr_t i_ex_dst,
	input  logic      i_ex_mem_read,
	input  mem_wb_t   i_mem_wb,
	output id_ex_t    o_id_ex,
	output logic      o_stall,
	output logic      o_jump,
	output word_t     o_jump_target
);

	word_t     regs [32];
	opcode_t   opcode;
	funct_t    funct;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	reg_addr_t dst;
	word_t     pc4;
	word_t     imm;
	word_t     rs_val;
	word_t     rt_val;
	alu_op_e   alu_op;
	logic      imm_src;
	logic      mem_read;
	logic      mem_write;
	logic      reg_wr;
	logic      is_branch;
	logic      is_jump;
	logic      uses_rs;
	logic      uses_rt;
	logic      hazard;

	assign opcode = i_if_id.instr[31:26];
	assign rs     = i_if_id.instr[25:21];
	assign rt     = i_if_id.instr[20:16];
	assign rd     = i_if_id.instr[15:11];
	assign funct  = i_if_id.instr[5:0];
	assign pc4    = i_if_id.pc + 32'd4;
	assign imm    = {{16{i_if_id.instr[15]}}, i_if_id.instr[15:0]};

	always_comb begin
		alu_op    = ALU_ADD;
		imm_src   = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		reg_wr    = 1'b0;
		is_branch = 1'b0;
		is_jump   = 1'b0;
		uses_rs   = 1'b0;
		uses_rt   = 1'b0;
		dst       = rd;
		case (opcode)
			OP_SPECIAL: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				reg_wr  = 1'b1;
				case (funct)
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_SLT:  alu_op = ALU_SLT;
					default: reg_wr = 1'b0;
				endcase
			end
			OP_ADDIU, OP_LW: begin
				uses_rs  = 1'b1;
				imm_src  = 1'b1;
				reg_wr   = 1'b1;
				mem_read = (opcode == OP_LW);
				dst      = rt;
			end
			OP_SW: begin
				uses_rs   = 1'b1;
				uses_rt   = 1'b1;
				imm_src   = 1'b1;
				mem_write = 1'b1;
			end
			OP_BEQ: begin
				uses_rs   = 1'b1;
				uses_rt   = 1'b1;
				is_branch = 1'b1;
				alu_op    = ALU_SUB;
			end
			OP_J:    is_jump = 1'b1;
			default: ;
		endcase
	end

	// write-through so writeback and read can share a cycle
	assign rs_val = (rs == '0) ? '0 :
		(i_mem_wb.reg_write && i_mem_wb.dst == rs) ? i_mem_wb.result : regs[rs];
	assign rt_val = (rt == '0) ? '0 :
		(i_mem_wb.reg_write && i_mem_wb.dst == rt) ? i_mem_wb.result : regs[rt];

	always_ff @(posedge i_clk) begin
		if (i_mem_wb.reg_write)
			regs[i_mem_wb.dst] <= i_mem_wb.result;
	end

	// load in execute feeding this instruction
	assign hazard = i_ex_mem_read &&
		((uses_rs && rs == i_ex_dst) || (uses_rt && rt == i_ex_dst));
	assign o_stall = i_if_id.valid && !i_flush && hazard;

	assign o_jump        = i_if_id.valid && !i_flush && is_jump;
	assign o_jump_target = {pc4[31:28], i_if_id.instr[25:0], 2'b00};

	always_ff @(posedge i_clk) begin
		if (!i_rst_n || i_flush || o_stall) begin
			o_id_ex.valid     <= 1'b0;
			o_id_ex.mem_read  <= 1'b0;
			o_id_ex.mem_write <= 1'b0;
			o_id_ex.reg_write <= 1'b0;
			o_id_ex.is_branch <= 1'b0;
		end else begin
			o_id_ex.valid     <= i_if_id.valid;
			o_id_ex.pc4       <= pc4;
			o_id_ex.rs        <= rs;
			o_id_ex.rt        <= rt;
			o_id_ex.rs_val    <= rs_val;
			o_id_ex.rt_val    <= rt_val;
			o_id_ex.imm       <= imm;
			o_id_ex.dst       <= dst;
			o_id_ex.alu_op    <= alu_op;
			o_id_ex.imm_src   <= imm_src;
			o_id_ex.mem_read  <= i_if_id.valid && mem_read;
			o_id_ex.mem_write <= i_if_id.valid && mem_write;
			// writes to register 0 are dropped here
			o_id_ex.reg_write <= i_if_id.valid && reg_wr && (dst != '0);
			o_id_ex.is_branch <= i_if_id.valid && is_branch;
		end
	end

	a_no_zero_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_mem_wb.reg_write |-> i_mem_wb.dst != '0);

endmodule

// ==== source/execute.sv ====
`timescale 1ns/1ps

module execute import core_pkg::*, stage_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  id_ex_t    i_id_ex,
	input  ex_mem_t   i_ex_mem_fwd,
	input  mem_wb_t   i_mem_wb,
	output ex_mem_t   o_ex_mem,
	output logic      o_branch,
	output word_t     o_branch_target,
	output reg_addr_t o_dst,
	output logic      o_mem_read
);

	word_t op_a;
	word_t op_b_reg;
	word_t op_b;
	word_t alu_res;

	// memory stage result wins over writeback
	// loads are left out since decode stalls on them
	function automatic word_t fwd(reg_addr_t idx, word_t val, ex_mem_t em, mem_wb_t wb);
		if (em.reg_write && !em.mem_read && em.dst == idx)
			return em.result;
		else if (wb.reg_write && wb.dst == idx)
			return wb.result;
		return val;
	endfunction

	assign op_a     = fwd(i_id_ex.rs, i_id_ex.rs_val, i_ex_mem_fwd, i_mem_wb);
	assign op_b_reg = fwd(i_id_ex.rt, i_id_ex.rt_val, i_ex_mem_fwd, i_mem_wb);
	assign op_b     = i_id_ex.imm_src ? i_id_ex.imm : op_b_reg;

	always_comb begin
		case (i_id_ex.alu_op)
			ALU_ADD: alu_res = op_a + op_b;
			ALU_SUB: alu_res = op_a - op_b;
			ALU_AND: alu_res = op_a & op_b;
			ALU_OR:  alu_res = op_a | op_b;
			ALU_SLT: alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
			default: alu_res = '0;
		endcase
	end

	// beq taken when forwarded operands match
	assign o_branch        = i_id_ex.valid && i_id_ex.is_branch && (op_a == op_b_reg);
	assign o_branch_target = i_id_ex.pc4 + {i_id_ex.imm[29:0], 2'b00};

	assign o_dst      = i_id_ex.dst;
	assign o_mem_read = i_id_ex.valid && i_id_ex.mem_read;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_ex_mem.valid     <= 1'b0;
			o_ex_mem.mem_read  <= 1'b0;
			o_ex_mem.mem_write <= 1'b0;
			o_ex_mem.reg_write <= 1'b0;
		end else begin
			o_ex_mem.valid      <= i_id_ex.valid;
			o_ex_mem.result     <= alu_res;
			o_ex_mem.store_data <= op_b_reg;
			o_ex_mem.dst        <= i_id_ex.dst;
			o_ex_mem.mem_read   <= i_id_ex.valid && i_id_ex.mem_read;
			o_ex_mem.mem_write  <= i_id_ex.valid && i_id_ex.mem_write;
			o_ex_mem.reg_write  <= i_id_ex.valid && i_id_ex.reg_write;
		end
	end

	// a taken branch leaves a bubble behind it from the decode flush
	a_branch_bubble: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_branch |=> !i_id_ex.valid);

endmodule

// ==== source/fetch.sv ====
`timescale 1ns/1ps

module fetch import core_pkg::*, stage_pkg::*; #(
	parameter word_t P_RESET_PC = 32'h0000_0000
) (
	input  logic   i_clk,
	input  logic   i_rst_n,
	input  word_t  i_instr,
	input  logic   i_stall,
	input  logic   i_jump,
	input  word_t  i_jump_target,
	input  logic   i_branch,
	input  word_t  i_branch_target,
	output word_t  o_pc,
	output if_id_t o_if_id
);

	// branch from execute wins over jump from decode
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_pc <= P_RESET_PC;
		end else if (i_branch) begin
			o_pc <= i_branch_target;
		end else if (i_jump) begin
			o_pc <= i_jump_target;
		end else if (!i_stall) begin
			o_pc <= o_pc + 32'd4;
		end
	end

	// a redirect squashes the word fetched this cycle
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_if_id.valid <= 1'b0;
		end else if (i_branch || i_jump) begin
			o_if_id.valid <= 1'b0;
		end else if (!i_stall) begin
			o_if_id.valid <= 1'b1;
			o_if_id.pc    <= o_pc;
			o_if_id.instr <= i_instr;
		end
	end

	a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_pc[1:0] == 2'b00);

endmodule

// ==== source/mem.sv ====
`timescale 1ns/1ps

module mem import core_pkg::*, stage_pkg::*; (
	input  logic    i_clk,
	input  logic    i_rst_n,
	input  ex_mem_t i_ex_mem,
	input  word_t   i_read_data,
	output mem_wb_t o_mem_wb
);

	word_t result;

	// writeback select folded in here
	assign result = i_ex_mem.mem_read ? i_read_data : i_ex_mem.result;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_mem_wb.reg_write <= 1'b0;
		end else begin
			o_mem_wb.result    <= result;
			o_mem_wb.dst       <= i_ex_mem.dst;
			o_mem_wb.reg_write <= i_ex_mem.valid && i_ex_mem.reg_write;
		end
	end

	a_rd_wr_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_ex_mem.mem_read && i_ex_mem.mem_write));

endmodule

// ==== source/stage_pkg.sv ====
package stage_pkg;

	import core_pkg::*;

	// fetch to decode
	typedef struct packed {
		logic  valid;
		word_t pc;
		word_t instr;
	} if_id_t;

	// decode to execute
	// branch target is built in execute from pc4 and imm
	typedef struct packed {
		logic      valid;
		word_t     pc4;
		reg_addr_t rs;
		reg_addr_t rt;
		word_t     rs_val;
		word_t     rt_val;
		word_t     imm;
		reg_addr_t dst;
		alu_op_e   alu_op;
		logic      imm_src;
		logic      mem_read;
		logic      mem_write;
		logic      reg_write;
		logic      is_branch;
	} id_ex_t;

	// execute to memory
	typedef struct packed {
		logic      valid;
		word_t     result;
		word_t     store_data;
		reg_addr_t dst;
		logic      mem_read;
		logic      mem_write;
		logic      reg_write;
	} ex_mem_t;

	// memory to writeback, reg_write already qualified by valid
	typedef struct packed {
		word_t     result;
		reg_addr_t dst;
		logic      reg_write;
	} mem_wb_t;

endpackage

// ==== verification/core_checker.sv ====
`timescale 1ns/1ps

module core_checker import core_pkg::*; #(
	parameter word_t P_RESET_PC   = 32'h0000_0000,
	parameter int    P_PROG_LEN   = 200,
	parameter int    P_DATA_WORDS = 64
) (
	input  logic  i_clk,
	input  logic  i_rst_n,
	input  word_t i_instr_addr,
	input  word_t i_data_addr,
	input  word_t i_write_data,
	input  logic  i_mem_write,
	input  logic  i_mem_read
);

	// loaded by the testbench before reset is released
	word_t prog [P_PROG_LEN];
	word_t data [P_DATA_WORDS];

	word_t exp_addr [$];
	word_t exp_data [$];
	int    errors = 0;
	int    stores_seen = 0;
	int    cycles = 0;
	logic  first_fetch_done = 1'b0;

	task automatic check_word(string name, word_t got, word_t want);
		if (got !== want) begin
			$display("ERROR at %0t ns: %s expected %h got %h", $time, name, want, got);
			errors++;
		end
	endtask

	// sequential instruction-set model, no delay slot
	task automatic run_model();
		word_t regs [32];
		word_t pc;
		word_t off;
		word_t iw;
		word_t a;
		word_t b;
		word_t imm;
		word_t addr;
		word_t res;
		word_t target;
		logic [4:0] dst;
		logic wr;
		logic done;
		int steps;
		for (int r = 0; r < 32; r++)
			regs[r] = '0;
		pc = P_RESET_PC;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 4 * P_PROG_LEN) begin
			off = (pc - P_RESET_PC) >> 2;
			iw = (off < P_PROG_LEN) ? prog[off] : '0;
			a = regs[iw[25:21]];
			b = regs[iw[20:16]];
			imm = {{16{iw[15]}}, iw[15:0]};
			addr = a + imm;
			pc = pc + 32'd4;
			wr = 1'b0;
			dst = iw[20:16];
			res = '0;
			case (iw[31:26])
				OP_SPECIAL: begin
					wr = 1'b1;
					dst = iw[15:11];
					case (iw[5:0])
						FN_ADDU: res = a + b;
						FN_SUBU: res = a - b;
						FN_AND:  res = a & b;
						FN_OR:   res = a | b;
						FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: wr = 1'b0;
					endcase
				end
				OP_ADDIU: begin
					wr = 1'b1;
					res = addr;
				end
				OP_LW: begin
					wr = 1'b1;
					res = data[(addr >> 2) % P_DATA_WORDS];
				end
				OP_SW: begin
					data[(addr >> 2) % P_DATA_WORDS] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
				end
				OP_BEQ: begin
					if (a == b)
						pc = pc + {imm[29:0], 2'b00};
				end
				OP_J: begin
					target = {pc[31:28], iw[25:0], 2'b00};
					// a jump to itself closes the program
					done = (target == pc - 32'd4);
					pc = target;
				end
				default: ;
			endcase
			if (wr && dst != 5'd0)
				regs[dst] = res;
			steps++;
		end
		if (!done) begin
			$display("instruction model never reached the closing self-jump");
			errors++;
		end
	endtask

	initial begin
		wait (i_rst_n === 1'b1);
		run_model();
	end

	always @(posedge i_clk)
		cycles <= cycles + 1;

	// outputs are registered, so the falling edge sees them settled
	always @(negedge i_clk) begin
		if (!i_rst_n) begin
			if (cycles > 0) begin
				check_word("o_mem_write", {31'd0, i_mem_write}, '0);
				check_word("o_mem_read", {31'd0, i_mem_read}, '0);
			end
		end else begin
			if (!first_fetch_done) begin
				first_fetch_done = 1'b1;
				check_word("o_instr_addr", i_instr_addr, P_RESET_PC);
			end
			if (i_mem_write === 1'b1) begin
				stores_seen++;
				if (exp_addr.size() == 0) begin
					$display("store to %h with data %h at %0t ns was never predicted",
						i_data_addr, i_write_data, $time);
					errors++;
				end else begin
					check_word("o_data_addr", i_data_addr, exp_addr.pop_front());
					check_word("o_write_data", i_write_data, exp_data.pop_front());
				end
			end
		end
	end

	task automatic report(output int total);
		if (exp_addr.size() != 0) begin
			$display("%0d predicted stores never appeared, first missing at address %h",
				exp_addr.size(), exp_addr[0]);
			errors += exp_addr.size();
		end
		$display("checker: %0d stores seen, %0d errors", stores_seen, errors);
		total = errors;
	endtask

endmodule

// ==== verification/tb_core.sv ====
`timescale 1ns/1ps

module tb_core import core_pkg::*; ();

	localparam word_t RESET_PC        = 32'h0000_0200;
	localparam int    PROG_LEN        = 200;
	localparam int    DATA_WORDS      = 64;
	localparam int    WATCHDOG_CYCLES = 4 * PROG_LEN + 200;
	localparam word_t END_PC          = RESET_PC + 4 * (PROG_LEN - 1);
	// pipeline depth plus a load-use stall and a redirect refetch
	localparam int    DRAIN_CYCLES    = 8;

	logic  clk;
	logic  rst_n;
	word_t instr;
	word_t read_data;
	word_t instr_addr;
	word_t data_addr;
	word_t write_data;
	logic  mem_write;
	logic  mem_read;
	word_t imem [PROG_LEN];
	word_t dmem [DATA_WORDS];
	int    seed = 92;
	int    errors;

	core #(
		.P_RESET_PC(RESET_PC)
	) u_dut (
		.i_clk(clk),
		.i_rst_n(rst_n),
		.i_instr(instr),
		.i_read_data(read_data),
		.o_instr_addr(instr_addr),
		.o_data_addr(data_addr),
		.o_write_data(write_data),
		.o_mem_write(mem_write),
		.o_mem_read(mem_read)
	);

	core_checker #(
		.P_RESET_PC(RESET_PC),
		.P_PROG_LEN(PROG_LEN),
		.P_DATA_WORDS(DATA_WORDS)
	) u_checker (
		.i_clk(clk),
		.i_rst_n(rst_n),
		.i_instr_addr(instr_addr),
		.i_data_addr(data_addr),
		.i_write_data(write_data),
		.i_mem_write(mem_write),
		.i_mem_read(mem_read)
	);

	function automatic int rand_below(int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % n;
	endfunction

	function automatic logic [4:0] pick_reg();
		return 5'(1 + rand_below(7));
	endfunction

	function automatic funct_t pick_funct();
		case (rand_below(5))
			0:       return FN_ADDU;
			1:       return FN_SUBU;
			2:       return FN_AND;
			3:       return FN_OR;
			default: return FN_SLT;
		endcase
	endfunction

	// seed registers first, then a random mix, then a jump to itself
	task automatic build_program();
		int kind;
		int reach;
		for (int i = 0; i < PROG_LEN; i++) begin
			kind = rand_below(100);
			// forward targets stay at or before the final jump
			reach = (PROG_LEN - 1 - i < 6) ? PROG_LEN - 1 - i : 6;
			if (i < 7)
				imem[i] = {OP_ADDIU, 5'd0, 5'(i + 1), 16'(rand_below(65536))};
			else if (i == PROG_LEN - 1)
				imem[i] = {OP_J, 26'((RESET_PC >> 2) + i)};
			else if (kind < 40)
				imem[i] = {OP_SPECIAL, pick_reg(), pick_reg(), pick_reg(), 5'd0, pick_funct()};
			else if (kind < 50)
				imem[i] = {OP_ADDIU, pick_reg(), pick_reg(), 16'(rand_below(65536))};
			else if (kind < 65)
				imem[i] = {OP_LW, 5'd0, pick_reg(), 16'(rand_below(DATA_WORDS) * 4)};
			else if (kind < 88)
				imem[i] = {OP_SW, 5'd0, pick_reg(), 16'(rand_below(DATA_WORDS) * 4)};
			else if (kind < 96)
				imem[i] = {OP_BEQ, pick_reg(), pick_reg(), 16'(rand_below(reach))};
			else
				imem[i] = {OP_J, 26'((RESET_PC >> 2) + i + 1 + rand_below(reach))};
		end
	endtask

	function automatic word_t fetch_word(word_t addr);
		word_t off;
		off = (addr - RESET_PC) >> 2;
		if (off < PROG_LEN)
			return imem[off];
		return '0;
	endfunction

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// memories answer a fixed delay after the edge
	always @(posedge clk) begin
		#1;
		instr = fetch_word(instr_addr);
		read_data = dmem[(data_addr >> 2) % DATA_WORDS];
	end

	always @(posedge clk) begin
		if (mem_write === 1'b1)
			dmem[(data_addr >> 2) % DATA_WORDS] <= write_data;
	end

	initial begin
		rst_n = 1'b0;
		instr = '0;
		read_data = '0;
		build_program();
		for (int i = 0; i < DATA_WORDS; i++)
			dmem[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0000 ^ i;
		for (int i = 0; i < PROG_LEN; i++)
			u_checker.prog[i] = imem[i];
		for (int i = 0; i < DATA_WORDS; i++)
			u_checker.data[i] = dmem[i];
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;
		wait (instr_addr == END_PC);
		repeat (DRAIN_CYCLES) @(posedge clk);
		u_checker.report(errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog: program did not reach its closing jump in %0d cycles",
			WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
